//--- verilog/md5Pkg.sv
`default_nettype none

package md5Pkg;

  localparam int WordWidth   = 32;
  localparam int DigestWidth = 128;
  localparam int NumSteps    = 64;
  // edges from sampling a candidate to its swapped digest
  localparam int PipeLatency = NumSteps + 1;

  typedef logic [WordWidth-1:0]   word_t;
  typedef logic [DigestWidth-1:0] digest_t;

  typedef enum logic [1:0] {FuncF, FuncG, FuncH, FuncI} roundFunc_e;

  localparam word_t InitA = 32'h67452301;
  localparam word_t InitB = 32'hefcdab89;
  localparam word_t InitC = 32'h98badcfe;
  localparam word_t InitD = 32'h10325476;

  //**********************************************************
  // per-step tables
  //**********************************************************

  localparam word_t SineTable [0:NumSteps-1] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // four rotate amounts per round
  localparam int ShiftTable [0:15] = '{
    7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21
  };

  function automatic word_t stepConstant(int step);
    return SineTable[step];
  endfunction

  function automatic int stepShift(int step);
    return ShiftTable[(step / 16) * 4 + (step % 4)];
  endfunction

  function automatic roundFunc_e stepFunc(int step);
    return roundFunc_e'(step / 16);
  endfunction

  // true where the message schedule picks word 0
  function automatic bit stepUsesCandidate(int step);
    int msgIndex;
    case (step / 16)
      0: msgIndex = step;
      1: msgIndex = (5 * step + 1) % 16;
      2: msgIndex = (3 * step + 5) % 16;
      default: msgIndex = (7 * step) % 16;
    endcase
    return msgIndex == 0;
  endfunction

  //**********************************************************
  // word helpers
  //**********************************************************

  function automatic word_t roundFunc(roundFunc_e op, word_t b, word_t c, word_t d);
    case (op)
      FuncF: return (b & c) | (~b & d);
      FuncG: return (b & d) | (c & ~d);
      FuncH: return b ^ c ^ d;
      default: return c ^ (b | ~d);
    endcase
  endfunction

  function automatic word_t rotl(word_t w, int amount);
    return (w << amount) | (w >> (WordWidth - amount));
  endfunction

  // MD5 words are little endian
  function automatic word_t byteSwap(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

`default_nettype wire

//--- verilog/md5DigestIf.sv
`timescale 1ns/1ps
`default_nettype none

// digest words in output byte order
interface md5DigestIf;

  md5Pkg::word_t wordA;
  md5Pkg::word_t wordB;
  md5Pkg::word_t wordC;
  md5Pkg::word_t wordD;

  modport source (
    output wordA, wordB, wordC, wordD
  );

  modport sink (
    input wordA, wordB, wordC, wordD
  );

endinterface

`default_nettype wire

//--- verilog/md5RoundPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module md5RoundPipeline (
  input  logic          CLK,
  input  md5Pkg::word_t counterIn,
  md5DigestIf.source    digest
);

  // state entering each step and the fed-forward result at the end
  md5Pkg::word_t stateA [0:md5Pkg::NumSteps];
  md5Pkg::word_t stateB [0:md5Pkg::NumSteps];
  md5Pkg::word_t stateC [0:md5Pkg::NumSteps];
  md5Pkg::word_t stateD [0:md5Pkg::NumSteps];

  // swapped candidate travelling with its step
  md5Pkg::word_t candPipe [0:md5Pkg::NumSteps-1];

  assign stateA[0] = md5Pkg::InitA;
  assign stateB[0] = md5Pkg::InitB;
  assign stateC[0] = md5Pkg::InitC;
  assign stateD[0] = md5Pkg::InitD;

  always_ff @(posedge CLK)
  begin
    candPipe[0] <= md5Pkg::byteSwap(counterIn);
  end

  //**********************************************************
  // compression steps
  //**********************************************************

  for (genvar i = 0; i < md5Pkg::NumSteps; i++)
  begin : stepGen
    localparam md5Pkg::roundFunc_e Func = md5Pkg::stepFunc(i);
    localparam int Shift = md5Pkg::stepShift(i);
    localparam md5Pkg::word_t StepK = md5Pkg::stepConstant(i);
    localparam bit UsesCand = md5Pkg::stepUsesCandidate(i);
    localparam bit IsLast = (i == md5Pkg::NumSteps - 1);

    // chaining words added back only after the final step
    localparam md5Pkg::word_t AddA = IsLast ? md5Pkg::InitA : '0;
    localparam md5Pkg::word_t AddB = IsLast ? md5Pkg::InitB : '0;
    localparam md5Pkg::word_t AddC = IsLast ? md5Pkg::InitC : '0;
    localparam md5Pkg::word_t AddD = IsLast ? md5Pkg::InitD : '0;

    md5Pkg::word_t msgWord;
    md5Pkg::word_t funcOut;
    md5Pkg::word_t stepSum;
    md5Pkg::word_t newB;

    assign msgWord = UsesCand ? candPipe[i] : '0;
    assign funcOut = md5Pkg::roundFunc(Func, stateB[i], stateC[i], stateD[i]);
    assign stepSum = stateA[i] + funcOut + StepK + msgWord;
    assign newB    = stateB[i] + md5Pkg::rotl(stepSum, Shift);

    // usual rotation of the four words
    always_ff @(posedge CLK)
    begin
      stateA[i+1] <= stateD[i] + AddA;
      stateB[i+1] <= newB + AddB;
      stateC[i+1] <= stateB[i] + AddC;
      stateD[i+1] <= stateC[i] + AddD;
    end

    if (i < md5Pkg::NumSteps - 1)
    begin : candCopy
      always_ff @(posedge CLK)
      begin
        candPipe[i+1] <= candPipe[i];
      end
    end
  end

  //**********************************************************
  // output byte order
  //**********************************************************

  always_ff @(posedge CLK)
  begin
    digest.wordA <= md5Pkg::byteSwap(stateA[md5Pkg::NumSteps]);
    digest.wordB <= md5Pkg::byteSwap(stateB[md5Pkg::NumSteps]);
    digest.wordC <= md5Pkg::byteSwap(stateC[md5Pkg::NumSteps]);
    digest.wordD <= md5Pkg::byteSwap(stateD[md5Pkg::NumSteps]);
  end

endmodule

`default_nettype wire

//--- verilog/candidateTracker.sv
`timescale 1ns/1ps
`default_nettype none

module candidateTracker #(
  parameter int Depth = md5Pkg::PipeLatency
) (
  input  logic          CLK,
  input  logic          reset,
  input  md5Pkg::word_t counterIn,
  output md5Pkg::word_t trackedCounter,
  output logic          trackedValid
);

  // entry k holds what was sampled k edges earlier
  md5Pkg::word_t candDelay [0:Depth];
  logic [Depth:0] fillDelay;

  always_ff @(posedge CLK)
  begin
    candDelay[0] <= counterIn;
    for (int k = 1; k <= Depth; k++)
    begin
      candDelay[k] <= candDelay[k-1];
    end
  end

  // candidates taken during reset never count as filled
  always_ff @(posedge CLK)
  begin
    if (reset)
      fillDelay <= '0;
    else
      fillDelay <= {fillDelay[Depth-1:0], 1'b1};
  end

  assign trackedCounter = candDelay[Depth];
  assign trackedValid   = fillDelay[Depth];

endmodule

`default_nettype wire

//--- verilog/matchLatch.sv
`timescale 1ns/1ps
`default_nettype none

module matchLatch (
  input  logic            CLK,
  input  logic            reset,
  md5DigestIf.sink        digest,
  input  md5Pkg::digest_t targetHash,
  input  md5Pkg::word_t   trackedCounter,
  input  logic            trackedValid,
  output logic            found,
  output md5Pkg::word_t   foundCounter
);

  md5Pkg::digest_t digestValue;
  logic            isMatch;

  // word A lands in the top bits
  assign digestValue = {digest.wordA, digest.wordB, digest.wordC, digest.wordD};
  assign isMatch     = trackedValid && (digestValue == targetHash);

  // first match wins, held until reset
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      found        <= 1'b0;
      foundCounter <= '0;
    end
    else if (isMatch && !found)
    begin
      found        <= 1'b1;
      foundCounter <= trackedCounter;
    end
  end

endmodule

`default_nettype wire

//--- verilog/md5Search.sv
`timescale 1ns/1ps
`default_nettype none

module md5Search (
  input  logic            CLK,
  input  logic            reset,
  input  md5Pkg::word_t   counterIn,
  input  md5Pkg::digest_t targetHash,
  output logic            found,
  output md5Pkg::word_t   foundCounter
);

  md5DigestIf digestBus ();

  md5Pkg::word_t trackedCounter;
  logic          trackedValid;

  md5RoundPipeline i_pipeline (
    .CLK       (CLK),
    .counterIn (counterIn),
    .digest    (digestBus.source)
  );

  // runs beside the pipeline with matching latency
  candidateTracker #(
    .Depth (md5Pkg::PipeLatency)
  ) i_tracker (
    .CLK            (CLK),
    .reset          (reset),
    .counterIn      (counterIn),
    .trackedCounter (trackedCounter),
    .trackedValid   (trackedValid)
  );

  matchLatch i_matchLatch (
    .CLK            (CLK),
    .reset          (reset),
    .digest         (digestBus.sink),
    .targetHash     (targetHash),
    .trackedCounter (trackedCounter),
    .trackedValid   (trackedValid),
    .found          (found),
    .foundCounter   (foundCounter)
  );

endmodule

`default_nettype wire

//--- dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int PeriodNs = 8
) (
  output logic CLK
);

  // free running, starts low
  initial
  begin
    CLK = 1'b0;
    forever
    begin
      #(PeriodNs / 2.0) CLK = ~CLK;
    end
  end

endmodule

`default_nettype wire

//--- include/md5RefModel.svh
`ifndef MD5_REF_MODEL_SVH
`define MD5_REF_MODEL_SVH

// one unpadded block with the byte-swapped candidate as word 0
// additive constants come from the sine of the step number
function automatic md5Pkg::digest_t md5RefDigest(md5Pkg::word_t candidate);
  int unsigned shifts [0:15] = '{7, 12, 17, 22, 5, 9, 14, 20,
                                 4, 11, 16, 23, 6, 10, 15, 21};
  logic [31:0] msg [0:15];
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [31:0] f;
  logic [31:0] k;
  logic [31:0] tmp;
  logic [31:0] rot;
  int unsigned g;
  int unsigned s;
  real sineAbs;

  foreach (msg[j])
  begin
    msg[j] = '0;
  end
  msg[0] = {<<8{candidate}};

  a = 32'h67452301;
  b = 32'hefcdab89;
  c = 32'h98badcfe;
  d = 32'h10325476;

  for (int i = 0; i < 64; i++)
  begin
    if (i < 16)
    begin
      f = (b & c) | (~b & d);
      g = i;
    end
    else if (i < 32)
    begin
      f = (d & b) | (~d & c);
      g = (5 * i + 1) % 16;
    end
    else if (i < 48)
    begin
      f = b ^ c ^ d;
      g = (3 * i + 5) % 16;
    end
    else
    begin
      f = c ^ (b | ~d);
      g = (7 * i) % 16;
    end
    sineAbs = $sin(i + 1);
    if (sineAbs < 0.0)
      sineAbs = -sineAbs;
    k = 32'(longint'($floor(sineAbs * 4294967296.0)));
    s = shifts[(i / 16) * 4 + (i % 4)];
    tmp = a + f + k + msg[g];
    rot = (tmp << s) | (tmp >> (32 - s));
    a = d;
    d = c;
    c = b;
    b = b + rot;
  end

  a = a + 32'h67452301;
  b = b + 32'hefcdab89;
  c = c + 32'h98badcfe;
  d = d + 32'h10325476;

  // each word in output byte order
  a = {<<8{a}};
  b = {<<8{b}};
  c = {<<8{c}};
  d = {<<8{d}};
  return {a, b, c, d};
endfunction

`endif

//--- dv/md5Search_tb.sv
`timescale 1ns/1ps
`default_nettype none

module md5Search_tb;

  // about one pipeline fill plus slack per sequence
  localparam int CycleLimit = 4 * (md5Pkg::PipeLatency + 40);
  // digest registered, then one more edge in the match latch
  localparam int FoundDelay = md5Pkg::PipeLatency + 1;

  logic            CLK;
  logic            reset;
  md5Pkg::word_t   counterIn;
  md5Pkg::digest_t targetHash;
  logic            found;
  md5Pkg::word_t   foundCounter;

  md5Pkg::digest_t targetWanted;
  int unsigned     edgeCount = 0;

  `include "md5RefModel.svh"

  tbClock #(
    .PeriodNs (8)
  ) i_clock (
    .CLK (CLK)
  );

  md5Search i_dut (
    .CLK          (CLK),
    .reset        (reset),
    .counterIn    (counterIn),
    .targetHash   (targetHash),
    .found        (found),
    .foundCounter (foundCounter)
  );

  //**********************************************************
  // error reporting
  //**********************************************************

  task automatic failRun();
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic reportValue(input string testName, input logic [127:0] expected,
                             input logic [127:0] actual);
    $display("[FAIL] %s: expected %0h, actual %0h", testName, expected, actual);
    failRun();
  endtask

  task automatic reportFault(input string what);
    $display("ERROR: %s", what);
    failRun();
  endtask

  // run limit
  always @(posedge CLK)
  begin
    edgeCount <= edgeCount + 1;
    if (edgeCount >= CycleLimit)
      reportFault("cycle limit reached before all sequences finished");
  end

  resetClears: assert property (@(posedge CLK)
      reset |=> (found == 1'b0 && foundCounter == '0))
    else reportFault("found or foundCounter still set one edge after reset");

  stickyHold: assert property (@(posedge CLK)
      (found && !reset) |=> (found && $stable(foundCounter)))
    else reportFault("found dropped or foundCounter changed without a reset");

  //**********************************************************
  // stimulus helpers
  //**********************************************************

  // drive on the rising edge and read on the falling edge
  task automatic driveCycle(input md5Pkg::word_t value, input logic resetLevel);
    @(posedge CLK);
    counterIn  <= value;
    reset      <= resetLevel;
    targetHash <= targetWanted;
    @(negedge CLK);
  endtask

  task automatic expectIdle(input string testName);
    assert (found === 1'b0)
      else reportValue(testName, 128'(0), 128'(found));
    assert (foundCounter === '0)
      else reportValue(testName, 128'(0), 128'(foundCounter));
  endtask

  task automatic expectHeld(input string testName, input md5Pkg::word_t expected);
    assert (found === 1'b1)
      else reportValue(testName, 128'(1), 128'(found));
    assert (foundCounter === expected)
      else reportValue(testName, 128'(expected), 128'(foundCounter));
  endtask

  // sweep up through matchValue until found rises, then check latency
  task automatic sweepToMatch(input string testName, input md5Pkg::word_t matchValue,
                              output md5Pkg::word_t nextValue);
    md5Pkg::word_t value;
    int unsigned   matchEdge;
    value = matchValue - 32'd4;
    matchEdge = 0;
    for (int n = 0; n < md5Pkg::PipeLatency + 20; n++)
    begin
      driveCycle(value, 1'b0);
      // sampled on the next rising edge
      if (value == matchValue)
        matchEdge = edgeCount + 1;
      value = value + 32'd1;
      if (found === 1'b1)
        break;
    end
    assert (found === 1'b1)
      else reportFault({testName, ": found never rose after the matching candidate"});
    assert (edgeCount == matchEdge + FoundDelay)
      else reportValue(testName, 128'(matchEdge + FoundDelay), 128'(edgeCount));
    assert (foundCounter === matchValue)
      else reportValue(testName, 128'(matchValue), 128'(foundCounter));
    nextValue = value;
  endtask

  //**********************************************************
  // sequences
  //**********************************************************

  initial
  begin
    md5Pkg::word_t guardValue;
    md5Pkg::word_t firstValue;
    md5Pkg::word_t secondValue;
    md5Pkg::word_t sweepValue;

    void'($urandom(32'hc40a_1f79));
    guardValue  = $urandom();
    firstValue  = $urandom();
    secondValue = $urandom();

    // matching candidate offered only while reset is high
    targetWanted = md5RefDigest(guardValue);
    targetHash   = targetWanted;
    counterIn    = guardValue;
    reset        = 1'b1;
    repeat (2)
    begin
      driveCycle(guardValue, 1'b1);
    end
    for (int n = 1; n <= md5Pkg::PipeLatency + 10; n++)
    begin
      driveCycle(guardValue + n, 1'b0);
      expectIdle("fillGuard");
    end

    targetWanted = md5RefDigest(firstValue);
    sweepToMatch("singleMatch", firstValue, sweepValue);

    // later values, then the match again
    for (int n = 0; n < 20; n++)
    begin
      driveCycle(sweepValue, 1'b0);
      sweepValue = sweepValue + 32'd1;
      expectHeld("stickyFirst", firstValue);
    end
    driveCycle(firstValue, 1'b0);
    expectHeld("stickyFirst", firstValue);
    for (int n = 0; n < md5Pkg::PipeLatency + 5; n++)
    begin
      driveCycle(sweepValue, 1'b0);
      sweepValue = sweepValue + 32'd1;
      expectHeld("stickyFirst", firstValue);
    end

    // a different candidate matching later must not replace the first
    targetWanted = md5RefDigest(sweepValue);
    for (int n = 0; n < md5Pkg::PipeLatency + 5; n++)
    begin
      driveCycle(sweepValue, 1'b0);
      sweepValue = sweepValue + 32'd1;
      expectHeld("laterMatchIgnored", firstValue);
    end

    // new target loaded with a single reset cycle
    targetWanted = md5RefDigest(secondValue);
    driveCycle(sweepValue, 1'b1);
    driveCycle(sweepValue + 32'd1, 1'b0);
    expectIdle("resetClear");
    sweepToMatch("matchAfterReset", secondValue, sweepValue);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- md5Search.f
+incdir+include
verilog/md5Pkg.sv
verilog/md5DigestIf.sv
verilog/md5RoundPipeline.sv
verilog/candidateTracker.sv
verilog/matchLatch.sv
verilog/md5Search.sv
dv/tbClock.sv
dv/md5Search_tb.sv

//--- Bender.yml
package:
  name: md5Search

sources:
  - verilog/md5Pkg.sv
  - verilog/md5DigestIf.sv
  - verilog/md5RoundPipeline.sv
  - verilog/candidateTracker.sv
  - verilog/matchLatch.sv
  - verilog/md5Search.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tbClock.sv
      - dv/md5Search_tb.sv
